// ==== src/corePkg.sv ====
`default_nettype none

package corePkg;

	localparam int DATA_W = 16;
	localparam int ADDR_W = 8;

	// instruction group, bits 15..14
	typedef enum logic [1:0] {
		grpSystem,
		grpLoadStore,
		grpJump,
		grpArithLogic
	} groupT;

	typedef enum logic [2:0] {
		opAdd, opSub, opAnd, opOr, opXor, opShl1, opShr1, opMov
	} aluOpT;

	typedef enum logic [1:0] {condAlways, condZero, condNotZero, condLink} jumpCondT;

	// system group, bits 13..12
	typedef enum logic [1:0] {sysNop, sysHalt} sysOpT;

	typedef enum logic [1:0] {phFetch, phDecode, phExecute, phCommit} phaseT;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// selector codes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic {addrPc, addrAluResult} addrBusSelT;

	typedef enum logic [1:0] {dataAluResult, dataMemData, dataLinkPc} dataBusSelT;

	typedef enum logic [1:0] {bSrcRegB, bSrcImm4, bSrcOff5} aluBSrcT;

	typedef enum logic [1:0] {
		beNone = 2'b00,
		beLow  = 2'b01,
		beBoth = 2'b11
	} byteEnT;

endpackage

`default_nettype wire

// ==== src/ctrlIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ctrlIf import corePkg::*; ();

	aluOpT      aluOp;
	aluBSrcT    aluBSrc;
	dataBusSelT dataBusSel;
	addrBusSelT addrBusSel;
	// port A is rd, read and written
	logic       regAEn;
	logic       regAWen;
	byteEnT     regAByteEn;
	logic [2:0] regAAddr;
	// port B is rs or base, read only
	logic       regBEn;
	logic [2:0] regBAddr;
	logic       memRd;
	logic       memWr;
	logic       byteAccess;
	logic       jumpEn;
	jumpCondT   jumpCond;

	modport src (output aluOp, aluBSrc, dataBusSel, addrBusSel, regAEn, regAWen, regAByteEn,
		regAAddr, regBEn, regBAddr, memRd, memWr, byteAccess, jumpEn, jumpCond);

	modport sel (output aluOp, aluBSrc, dataBusSel, addrBusSel, regAEn, regAWen, regAByteEn,
		regAAddr, regBEn, regBAddr, memRd, memWr, byteAccess, jumpEn, jumpCond);

	modport dst (input aluOp, aluBSrc, dataBusSel, addrBusSel, regAEn, regAWen, regAByteEn,
		regAAddr, regBEn, regBAddr, memRd, memWr, byteAccess, jumpEn, jumpCond);

endinterface

`default_nettype wire

// ==== src/phaseSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module phaseSequencer import corePkg::*; #(
	parameter int DATA_W = corePkg::DATA_W,
	parameter int ADDR_W = corePkg::ADDR_W
) (
	input  logic              CLK,
	input  logic              rst,
	output phaseT             phase,
	output logic [ADDR_W-1:0] pc,
	output logic [DATA_W-1:0] instr,
	input  logic              jumpTaken,
	input  logic [ADDR_W-1:0] jumpTarget,
	input  logic              memAccess,
	input  logic [ADDR_W-1:0] dataAddr,
	input  logic [DATA_W-1:0] storeData,
	input  logic              byteAccess,
	input  logic              isHalt,
	output logic              memReqValid,
	input  logic              memReqReady,
	output logic [ADDR_W-1:0] memAddr,
	output logic              memWe,
	output logic [1:0]        memByteEn,
	output logic [DATA_W-1:0] memWdata,
	input  logic              memRespValid,
	input  logic [DATA_W-1:0] memRdata,
	output logic [DATA_W-1:0] loadData,
	output logic              loadDone,
	output logic              retireValid,
	output logic              halted
);

	// store bit of the load/store format
	localparam int STORE_BIT = 13;

	logic waitResp;

	assign retireValid = (phase == phCommit);

	always_ff @(posedge CLK) begin
		if (rst) begin
			phase       <= phFetch;
			pc          <= '0;
			memReqValid <= 1'b0;
			memWe       <= 1'b0;
			waitResp    <= 1'b0;
			loadDone    <= 1'b0;
			halted      <= 1'b0;
		end else begin
			case (phase)
				phFetch: begin
					if (memReqValid) begin
						if (memReqReady) begin
							memReqValid <= 1'b0;
							waitResp    <= 1'b1;
						end
					end else if (waitResp) begin
						if (memRespValid) begin
							instr    <= memRdata;
							waitResp <= 1'b0;
							phase    <= phDecode;
						end
					end else if (!halted) begin
						memReqValid <= 1'b1;
						memAddr     <= pc;
						memWe       <= 1'b0;
						memByteEn   <= beBoth;
					end
				end

				phDecode: begin
					loadDone <= 1'b0;
					phase    <= phExecute;
				end

				phExecute: begin
					if (!memAccess) begin
						phase <= phCommit;
					end else if (memReqValid) begin
						// a store is done once accepted, a load waits for data
						if (memReqReady) begin
							memReqValid <= 1'b0;
							memWe       <= 1'b0;
							if (memWe)
								phase <= phCommit;
							else
								waitResp <= 1'b1;
						end
					end else if (waitResp) begin
						if (memRespValid) begin
							loadData <= memRdata;
							loadDone <= 1'b1;
							waitResp <= 1'b0;
							phase    <= phCommit;
						end
					end else begin
						memReqValid <= 1'b1;
						memAddr     <= dataAddr;
						memWe       <= instr[STORE_BIT];
						memWdata    <= storeData;
						memByteEn   <= byteAccess ? beLow : beBoth;
					end
				end

				phCommit: begin
					pc    <= jumpTaken ? jumpTarget : pc + 1'b1;
					phase <= phFetch;
					if (isHalt)
						halted <= 1'b1;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/groupDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module groupDecode import corePkg::*; #(
	parameter int DATA_W = corePkg::DATA_W
) (
	input  logic [DATA_W-1:0] instr,
	ctrlIf.src                lsBundle,
	ctrlIf.src                jmpBundle,
	ctrlIf.src                aluBundle
);

	logic       isStore;
	logic       isByte;
	logic       useImm;
	jumpCondT   cond;
	logic [2:0] rd;
	logic [2:0] rs;

	assign isStore = instr[13];
	assign isByte  = instr[12];
	assign useImm  = instr[4];
	assign cond    = jumpCondT'(instr[13:12]);
	assign rd      = instr[10:8];
	assign rs      = instr[7:5];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// load/store: address is base + off5
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign lsBundle.aluOp      = opAdd;
	assign lsBundle.aluBSrc    = bSrcOff5;
	assign lsBundle.dataBusSel = dataMemData;
	assign lsBundle.addrBusSel = addrAluResult;
	assign lsBundle.regAEn     = isStore;
	assign lsBundle.regAWen    = !isStore;
	assign lsBundle.regAByteEn = isByte ? beLow : beBoth;
	assign lsBundle.regAAddr   = rd;
	assign lsBundle.regBEn     = 1'b1;
	assign lsBundle.regBAddr   = rs;
	assign lsBundle.memRd      = !isStore;
	assign lsBundle.memWr      = isStore;
	assign lsBundle.byteAccess = isByte;
	assign lsBundle.jumpEn     = 1'b0;
	assign lsBundle.jumpCond   = condAlways;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// jump: named register on port A
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign jmpBundle.aluOp      = opMov;
	assign jmpBundle.aluBSrc    = bSrcRegB;
	assign jmpBundle.dataBusSel = dataLinkPc;
	assign jmpBundle.addrBusSel = addrPc;
	assign jmpBundle.regAEn     = (cond == condZero) || (cond == condNotZero);
	assign jmpBundle.regAWen    = (cond == condLink);
	assign jmpBundle.regAByteEn = beBoth;
	assign jmpBundle.regAAddr   = rd;
	assign jmpBundle.regBEn     = 1'b0;
	assign jmpBundle.regBAddr   = rs;
	assign jmpBundle.memRd      = 1'b0;
	assign jmpBundle.memWr      = 1'b0;
	assign jmpBundle.byteAccess = 1'b0;
	assign jmpBundle.jumpEn     = 1'b1;
	assign jmpBundle.jumpCond   = cond;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// arithmetic/logic: rd op (imm4 or rs)
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign aluBundle.aluOp      = aluOpT'(instr[13:11]);
	assign aluBundle.aluBSrc    = useImm ? bSrcImm4 : bSrcRegB;
	assign aluBundle.dataBusSel = dataAluResult;
	assign aluBundle.addrBusSel = addrPc;
	assign aluBundle.regAEn     = 1'b1;
	assign aluBundle.regAWen    = 1'b1;
	assign aluBundle.regAByteEn = beBoth;
	assign aluBundle.regAAddr   = rd;
	assign aluBundle.regBEn     = !useImm;
	assign aluBundle.regBAddr   = rs;
	assign aluBundle.memRd      = 1'b0;
	assign aluBundle.memWr      = 1'b0;
	assign aluBundle.byteAccess = 1'b0;
	assign aluBundle.jumpEn     = 1'b0;
	assign aluBundle.jumpCond   = condAlways;

endmodule

`default_nettype wire

// ==== src/controlSelect.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlSelect import corePkg::*; #(
	parameter int DATA_W = corePkg::DATA_W
) (
	input  logic              CLK,
	input  logic              rst,
	input  logic [DATA_W-1:0] instr,
	input  phaseT             phase,
	ctrlIf.dst                lsBundle,
	ctrlIf.dst                jmpBundle,
	ctrlIf.dst                aluBundle,
	ctrlIf.sel                selBundle,
	output logic              isHalt
);

	groupT grp;
	logic  isLs;
	logic  isJmp;
	logic  isAlu;

	assign grp   = groupT'(instr[15:14]);
	assign isLs  = (grp == grpLoadStore);
	assign isJmp = (grp == grpJump);
	assign isAlu = (grp == grpArithLogic);

	assign isHalt = (grp == grpSystem) && (instr[13:12] == sysHalt);

	// system group falls through to idle controls
	assign selBundle.aluOp = isLs ? lsBundle.aluOp : isJmp ? jmpBundle.aluOp
		: isAlu ? aluBundle.aluOp : opMov;
	assign selBundle.aluBSrc = isLs ? lsBundle.aluBSrc : isJmp ? jmpBundle.aluBSrc
		: isAlu ? aluBundle.aluBSrc : bSrcRegB;
	assign selBundle.dataBusSel = isLs ? lsBundle.dataBusSel : isJmp ? jmpBundle.dataBusSel
		: isAlu ? aluBundle.dataBusSel : dataAluResult;
	assign selBundle.regAEn = isLs ? lsBundle.regAEn : isJmp ? jmpBundle.regAEn
		: isAlu ? aluBundle.regAEn : 1'b0;
	assign selBundle.regAWen = isLs ? lsBundle.regAWen : isJmp ? jmpBundle.regAWen
		: isAlu ? aluBundle.regAWen : 1'b0;
	assign selBundle.regAByteEn = isLs ? lsBundle.regAByteEn : isJmp ? jmpBundle.regAByteEn
		: isAlu ? aluBundle.regAByteEn : beNone;
	assign selBundle.regAAddr = isLs ? lsBundle.regAAddr : isJmp ? jmpBundle.regAAddr
		: isAlu ? aluBundle.regAAddr : 3'd0;
	assign selBundle.regBEn = isLs ? lsBundle.regBEn : isJmp ? jmpBundle.regBEn
		: isAlu ? aluBundle.regBEn : 1'b0;
	assign selBundle.regBAddr = isLs ? lsBundle.regBAddr : isJmp ? jmpBundle.regBAddr
		: isAlu ? aluBundle.regBAddr : 3'd0;
	assign selBundle.memRd = isLs ? lsBundle.memRd : isJmp ? jmpBundle.memRd
		: isAlu ? aluBundle.memRd : 1'b0;
	assign selBundle.memWr = isLs ? lsBundle.memWr : isJmp ? jmpBundle.memWr
		: isAlu ? aluBundle.memWr : 1'b0;
	assign selBundle.byteAccess = isLs ? lsBundle.byteAccess : isJmp ? jmpBundle.byteAccess
		: isAlu ? aluBundle.byteAccess : 1'b0;
	assign selBundle.jumpEn = isLs ? lsBundle.jumpEn : isJmp ? jmpBundle.jumpEn
		: isAlu ? aluBundle.jumpEn : 1'b0;
	assign selBundle.jumpCond = isLs ? lsBundle.jumpCond : isJmp ? jmpBundle.jumpCond
		: isAlu ? aluBundle.jumpCond : condAlways;

	// address source: pc through fetch, group's choice loaded at the end of decode
	always_ff @(posedge CLK) begin
		if (rst || phase == phFetch)
			selBundle.addrBusSel <= addrPc;
		else if (phase == phDecode)
			selBundle.addrBusSel <= isLs ? lsBundle.addrBusSel
				: isJmp ? jmpBundle.addrBusSel
				: isAlu ? aluBundle.addrBusSel : addrPc;
	end

endmodule

`default_nettype wire

// ==== src/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module registerFile import corePkg::*; #(
	parameter int DATA_W = corePkg::DATA_W
) (
	input  logic              CLK,
	input  logic              rst,
	input  logic [2:0]        addrA,
	input  logic [2:0]        addrB,
	output logic [DATA_W-1:0] dataA,
	output logic [DATA_W-1:0] dataB,
	input  logic              wen,
	input  logic [2:0]        wAddr,
	input  byteEnT            byteEn,
	input  logic [DATA_W-1:0] wData
);

	logic [DATA_W-1:0] regs [8];

	assign dataA = regs[addrA];
	assign dataB = regs[addrB];

	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end else if (wen && byteEn != beNone) begin
			regs[wAddr][7:0] <= wData[7:0];
			// high byte only for full-word writes
			if (byteEn == beBoth)
				regs[wAddr][DATA_W-1:8] <= wData[DATA_W-1:8];
		end
	end

endmodule

`default_nettype wire

// ==== src/executeUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeUnit import corePkg::*; #(
	parameter int DATA_W = corePkg::DATA_W,
	parameter int ADDR_W = corePkg::ADDR_W
) (
	input  logic              CLK,
	input  logic              rst,
	input  phaseT             phase,
	input  logic [ADDR_W-1:0] pc,
	input  logic [DATA_W-1:0] instr,
	ctrlIf.dst                selBundle,
	input  logic [DATA_W-1:0] dataA,
	input  logic [DATA_W-1:0] dataB,
	output logic [DATA_W-1:0] aluResult,
	output logic              jumpTaken,
	output logic [ADDR_W-1:0] jumpTarget,
	output logic              memAccess,
	output logic [ADDR_W-1:0] dataAddr,
	output logic [DATA_W-1:0] storeData,
	output logic              byteAccess
);

	logic [DATA_W-1:0] regA, regB, opA, opB, aluOut;
	logic              condMet, memRdWr, capture;

	assign regA = selBundle.regAEn ? dataA : '0;
	assign regB = selBundle.regBEn ? dataB : '0;
	// base + offset takes its base from port B
	assign opA  = (selBundle.aluBSrc == bSrcOff5) ? regB : regA;

	always_comb begin
		case (selBundle.aluBSrc)
			bSrcImm4: opB = {{(DATA_W-4){1'b0}}, instr[3:0]};
			bSrcOff5: opB = {{(DATA_W-5){1'b0}}, instr[4:0]};
			default:  opB = regB;
		endcase
		case (selBundle.aluOp)
			opAdd:   aluOut = opA + opB;
			opSub:   aluOut = opA - opB;
			opAnd:   aluOut = opA & opB;
			opOr:    aluOut = opA | opB;
			opXor:   aluOut = opA ^ opB;
			opShl1:  aluOut = opA << 1;
			opShr1:  aluOut = opA >> 1;
			default: aluOut = opB;
		endcase
		case (selBundle.jumpCond)
			condZero:    condMet = (regA == '0);
			condNotZero: condMet = (regA != '0);
			default:     condMet = 1'b1;
		endcase
	end

	// operands are settled from decode on, so the data access can start in execute
	assign capture   = (phase == phDecode) || (phase == phExecute);
	assign memAccess = memRdWr && (selBundle.addrBusSel == addrAluResult);
	assign dataAddr  = aluResult[ADDR_W-1:0];

	always_ff @(posedge CLK) begin
		if (rst) begin
			jumpTaken  <= 1'b0;
			memRdWr    <= 1'b0;
			byteAccess <= 1'b0;
		end else if (capture) begin
			jumpTaken  <= selBundle.jumpEn && condMet;
			memRdWr    <= selBundle.memRd || selBundle.memWr;
			byteAccess <= selBundle.byteAccess;
		end
	end

	always_ff @(posedge CLK) begin
		if (capture) begin
			aluResult  <= aluOut;
			jumpTarget <= pc + ADDR_W'(instr[7:0]);
			storeData  <= regA;
		end
	end

endmodule

`default_nettype wire

// ==== src/resultCommit.sv ====
`timescale 1ns/1ps
`default_nettype none

module resultCommit import corePkg::*; #(
	parameter int DATA_W = corePkg::DATA_W,
	parameter int ADDR_W = corePkg::ADDR_W
) (
	input  phaseT             phase,
	input  logic [ADDR_W-1:0] pc,
	ctrlIf.dst                selBundle,
	input  logic [DATA_W-1:0] aluResult,
	input  logic [DATA_W-1:0] loadData,
	input  logic              loadDone,
	output logic              wen,
	output logic [2:0]        wAddr,
	output byteEnT            byteEn,
	output logic [DATA_W-1:0] wData,
	output logic [ADDR_W-1:0] retirePc,
	output logic              retireRegWe,
	output logic [2:0]        retireReg,
	output logic [DATA_W-1:0] retireData
);

	logic [ADDR_W-1:0] linkPc;
	logic              srcReady;

	assign linkPc = pc + 1'b1;

	always_comb begin
		case (selBundle.dataBusSel)
			dataMemData: begin
				// a byte load only carries the low byte
				if (selBundle.regAByteEn == beLow)
					wData = {{(DATA_W-8){1'b0}}, loadData[7:0]};
				else
					wData = loadData;
			end
			dataLinkPc: wData = DATA_W'(linkPc);
			default:    wData = aluResult;
		endcase
	end

	assign srcReady = (selBundle.dataBusSel != dataMemData) || loadDone;
	assign wen      = (phase == phCommit) && selBundle.regAWen && srcReady;
	assign wAddr    = selBundle.regAAddr;
	assign byteEn   = selBundle.regAByteEn;

	assign retirePc    = pc;
	assign retireRegWe = wen;
	assign retireReg   = wAddr;
	assign retireData  = wData;

endmodule

`default_nettype wire

// ==== src/coreTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module coreTop import corePkg::*; #(
	parameter int DATA_W = corePkg::DATA_W,
	parameter int ADDR_W = corePkg::ADDR_W
) (
	input  logic              CLK,
	input  logic              rst,
	output logic              memReqValid,
	input  logic              memReqReady,
	output logic [ADDR_W-1:0] memAddr,
	output logic              memWe,
	output logic [1:0]        memByteEn,
	output logic [DATA_W-1:0] memWdata,
	input  logic              memRespValid,
	input  logic [DATA_W-1:0] memRdata,
	output logic              retireValid,
	output logic [ADDR_W-1:0] retirePc,
	output logic              retireRegWe,
	output logic [2:0]        retireReg,
	output logic [DATA_W-1:0] retireData,
	output logic              halted
);

	phaseT             phase;
	logic [ADDR_W-1:0] pc, jumpTarget, dataAddr;
	logic [DATA_W-1:0] instr, storeData, loadData, dataA, dataB, aluResult, wData;
	logic              jumpTaken, memAccess, byteAccess, loadDone, isHalt, wen;
	logic [2:0]        wAddr;
	byteEnT            byteEn;

	ctrlIf lsIf ();
	ctrlIf jmpIf ();
	ctrlIf aluIf ();
	ctrlIf selIf ();

	phaseSequencer #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) phaseSequencer_inst (
		.CLK, .rst, .phase, .pc, .instr, .jumpTaken, .jumpTarget, .memAccess, .dataAddr,
		.storeData, .byteAccess, .isHalt, .memReqValid, .memReqReady, .memAddr, .memWe,
		.memByteEn, .memWdata, .memRespValid, .memRdata, .loadData, .loadDone, .retireValid,
		.halted
	);

	groupDecode #(.DATA_W(DATA_W)) groupDecode_inst (
		.instr, .lsBundle(lsIf.src), .jmpBundle(jmpIf.src), .aluBundle(aluIf.src)
	);

	controlSelect #(.DATA_W(DATA_W)) controlSelect_inst (
		.CLK, .rst, .instr, .phase, .lsBundle(lsIf.dst), .jmpBundle(jmpIf.dst),
		.aluBundle(aluIf.dst), .selBundle(selIf.sel), .isHalt
	);

	registerFile #(.DATA_W(DATA_W)) registerFile_inst (
		.CLK, .rst, .addrA(selIf.regAAddr), .addrB(selIf.regBAddr), .dataA, .dataB,
		.wen, .wAddr, .byteEn, .wData
	);

	executeUnit #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) executeUnit_inst (
		.CLK, .rst, .phase, .pc, .instr, .selBundle(selIf.dst), .dataA, .dataB, .aluResult,
		.jumpTaken, .jumpTarget, .memAccess, .dataAddr, .storeData, .byteAccess
	);

	resultCommit #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) resultCommit_inst (
		.phase, .pc, .selBundle(selIf.dst), .aluResult, .loadData, .loadDone, .wen, .wAddr,
		.byteEn, .wData, .retirePc, .retireRegWe, .retireReg, .retireData
	);

endmodule

`default_nettype wire

// ==== sim/coreChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module coreChecker (
	input  logic        CLK,
	input  logic        rst,
	input  logic [15:0] image [256],
	input  logic        memReqValid,
	input  logic        memReqReady,
	input  logic [7:0]  memAddr,
	input  logic        memWe,
	input  logic [1:0]  memByteEn,
	input  logic [15:0] memWdata,
	input  logic        retireValid,
	input  logic [7:0]  retirePc,
	input  logic        retireRegWe,
	input  logic [2:0]  retireReg,
	input  logic [15:0] retireData,
	input  logic        halted,
	output int          errors,
	output int          retired
);

	// architectural state before the next instruction retires
	logic [15:0] model [256];
	logic [15:0] regs [8];
	logic [7:0]  pc;
	logic        haltRetired;
	logic        haltCheckNext;
	logic        fetchDone;
	// data access of the current instruction was accepted
	logic        dataDone;
	logic        firstReq;
	logic        prevRst = 1'b0;
	// request seen stalled on the last edge
	logic        stalled;
	logic [7:0]  heldAddr;
	logic        heldWe;
	logic [1:0]  heldByteEn;
	logic [15:0] heldWdata;
	int          errorCount = 0;
	int          retireCount = 0;

	assign errors  = errorCount;
	assign retired = retireCount;

	task automatic compareValue(input string name, input logic [15:0] expVal,
		input logic [15:0] actVal);
		if (expVal !== actVal) begin
			errorCount++;
			$display("CHECK FAILED %s: expected 0x%h, actual 0x%h (pc 0x%h)", name, expVal,
				actVal, pc);
		end
	endtask

	task automatic reportError(input string what);
		errorCount++;
		$display("ERROR at %0t ns: %s", $time, what);
	endtask

	function automatic logic [7:0] modelDataAddr(input logic [15:0] ins);
		return regs[ins[7:5]][7:0] + {3'b000, ins[4:0]};
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// accepted memory requests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic checkRequest();
		logic [15:0] ins;
		ins = model[pc];
		if (!fetchDone) begin
			if (memWe) begin
				reportError("store request before the instruction was fetched");
			end else begin
				compareValue("memAddr", {8'h00, pc}, {8'h00, memAddr});
				fetchDone = 1'b1;
			end
		end else begin
			if (dataDone)
				reportError("second data request from one instruction");
			dataDone = 1'b1;
			if (memWe) begin
				if (ins[15:13] != 3'b011) begin
					reportError("store request from an instruction that is not a store");
				end else begin
					compareValue("memAddr", {8'h00, modelDataAddr(ins)}, {8'h00, memAddr});
					compareValue("memByteEn", {14'h0000, ins[12] ? 2'b01 : 2'b11},
						{14'h0000, memByteEn});
					if (ins[12])
						compareValue("memWdata[7:0]", {8'h00, regs[ins[10:8]][7:0]},
							{8'h00, memWdata[7:0]});
					else
						compareValue("memWdata", regs[ins[10:8]], memWdata);
				end
			end else if (ins[15:13] != 3'b010) begin
				reportError("data read from an instruction that is not a load");
			end else begin
				compareValue("memAddr", {8'h00, modelDataAddr(ins)}, {8'h00, memAddr});
			end
		end
	endtask

	task automatic retireStep();
		logic [15:0] ins;
		logic [15:0] opA;
		logic [15:0] opB;
		logic [15:0] result;
		logic [7:0]  addr;
		logic [7:0]  nextPc;
		logic        expWe;
		logic        taken;
		ins    = model[pc];
		nextPc = pc + 8'd1;
		expWe  = 1'b0;
		taken  = 1'b0;
		result = 16'h0000;
		compareValue("retirePc", {8'h00, pc}, {8'h00, retirePc});
		if (!fetchDone)
			reportError("instruction retired without an accepted fetch");
		case (ins[15:14])
			2'b00: haltRetired = (ins[13:12] == 2'b01);
			2'b01: begin
				if (!dataDone)
					reportError("load or store retired without an accepted data request");
				addr = modelDataAddr(ins);
				if (ins[13]) begin
					if (ins[12])
						model[addr][7:0] = regs[ins[10:8]][7:0];
					else
						model[addr] = regs[ins[10:8]];
				end else begin
					expWe = 1'b1;
					if (ins[12]) begin
						// high byte of rd is kept
						result = {8'h00, model[addr][7:0]};
						regs[ins[10:8]][7:0] = result[7:0];
					end else begin
						result = model[addr];
						regs[ins[10:8]] = result;
					end
				end
			end
			2'b10: begin
				case (ins[13:12])
					2'b01:   taken = (regs[ins[10:8]] == 16'h0000);
					2'b10:   taken = (regs[ins[10:8]] != 16'h0000);
					default: taken = 1'b1;
				endcase
				if (ins[13:12] == 2'b11) begin
					expWe  = 1'b1;
					result = {8'h00, nextPc};
					regs[ins[10:8]] = result;
				end
				if (taken)
					nextPc = pc + ins[7:0];
			end
			default: begin
				opA = regs[ins[10:8]];
				opB = ins[4] ? {12'h000, ins[3:0]} : regs[ins[7:5]];
				case (ins[13:11])
					3'd0:    result = opA + opB;
					3'd1:    result = opA - opB;
					3'd2:    result = opA & opB;
					3'd3:    result = opA | opB;
					3'd4:    result = opA ^ opB;
					3'd5:    result = opA << 1;
					3'd6:    result = opA >> 1;
					default: result = opB;
				endcase
				expWe = 1'b1;
				regs[ins[10:8]] = result;
			end
		endcase
		compareValue("retireRegWe", {15'h0000, expWe}, {15'h0000, retireRegWe});
		if (expWe && retireRegWe) begin
			compareValue("retireReg", {13'h0000, ins[10:8]}, {13'h0000, retireReg});
			compareValue("retireData", result, retireData);
		end
		pc        = nextPc;
		fetchDone = 1'b0;
		dataDone  = 1'b0;
		retireCount++;
	endtask

	always @(posedge CLK) begin
		if (rst) begin
			for (int i = 0; i < 256; i++)
				model[i] = image[i];
			for (int i = 0; i < 8; i++)
				regs[i] = 16'h0000;
			pc            = 8'h00;
			haltRetired   = 1'b0;
			haltCheckNext = 1'b0;
			fetchDone     = 1'b0;
			dataDone      = 1'b0;
			firstReq      = 1'b1;
			stalled       = 1'b0;
			retireCount   = 0;
		end else begin
			if (prevRst && (retireValid || memReqValid || halted))
				reportError("retireValid, memReqValid or halted is not low after reset");
			if (firstReq && memReqValid) begin
				compareValue("first memAddr", 16'h0000, {8'h00, memAddr});
				firstReq = 1'b0;
			end
			if (stalled) begin
				if (!memReqValid) begin
					reportError("memReqValid dropped while memReqReady was low");
				end else begin
					compareValue("memAddr", {8'h00, heldAddr}, {8'h00, memAddr});
					compareValue("memWe", {15'h0000, heldWe}, {15'h0000, memWe});
					compareValue("memByteEn", {14'h0000, heldByteEn}, {14'h0000, memByteEn});
					compareValue("memWdata", heldWdata, memWdata);
				end
			end
			if (haltCheckNext && !halted)
				reportError("halted did not rise after the halt retired");
			haltCheckNext = 1'b0;
			if (halted && !haltRetired)
				reportError("halted rose before a halt instruction retired");
			if (haltRetired && (retireValid || memReqValid)) begin
				reportError("retire or memory request after the core halted");
			end else begin
				if (memReqValid && memReqReady)
					checkRequest();
				if (retireValid) begin
					retireStep();
					haltCheckNext = haltRetired;
				end
			end
			stalled    = memReqValid && !memReqReady;
			heldAddr   = memAddr;
			heldWe     = memWe;
			heldByteEn = memByteEn;
			heldWdata  = memWdata;
		end
		prevRst = rst;
	end

endmodule

`default_nettype wire

// ==== sim/coreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module coreTb;

	localparam int DATA_W       = 16;
	localparam int ADDR_W       = 8;
	localparam int PERIOD_NS    = 100;
	localparam int RESET_CYCLES = 16;
	localparam int QUIET_CYCLES = 20;
	localparam int PROG_LEN     = 120;
	localparam int NUM_TESTS    = 4;
	localparam int SEED         = 32751;
	localparam int OP_SHL1      = 5;
	localparam int OP_MOV       = 7;
	localparam logic [15:0] HALT = 16'h1000;
	// every test may retire at most PROG_LEN instructions
	localparam longint TIMEOUT_NS = longint'(NUM_TESTS)
		* (RESET_CYCLES + QUIET_CYCLES + 200 * PROG_LEN) * PERIOD_NS;

	logic              CLK = 1'b0;
	logic              rst;
	logic              memReqValid;
	logic              memReqReady;
	logic [ADDR_W-1:0] memAddr;
	logic              memWe;
	logic [1:0]        memByteEn;
	logic [DATA_W-1:0] memWdata;
	logic              memRespValid;
	logic [DATA_W-1:0] memRdata;
	logic              retireValid;
	logic [ADDR_W-1:0] retirePc;
	logic              retireRegWe;
	logic [2:0]        retireReg;
	logic [DATA_W-1:0] retireData;
	logic              halted;
	logic [DATA_W-1:0] image [256];
	logic [DATA_W-1:0] mem [256];
	int                errors;
	int                retired;

	always #(PERIOD_NS / 2) CLK = ~CLK;

	coreTop #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) coreTop_inst (
		.CLK, .rst, .memReqValid, .memReqReady, .memAddr, .memWe, .memByteEn, .memWdata,
		.memRespValid, .memRdata, .retireValid, .retirePc, .retireRegWe, .retireReg,
		.retireData, .halted
	);

	coreChecker coreChecker_inst (
		.CLK, .rst, .image, .memReqValid, .memReqReady, .memAddr, .memWe, .memByteEn,
		.memWdata, .retireValid, .retirePc, .retireRegWe, .retireReg, .retireData, .halted,
		.errors, .retired
	);

	function automatic logic [15:0] aluInstr(input int op, input int rd, input int rs,
		input logic useImm, input int imm);
		return {2'b11, 3'(op), 3'(rd), 3'(rs), useImm, 4'(imm)};
	endfunction

	function automatic logic [15:0] randomInstr(input int at);
		int          kind;
		int          cond;
		logic        isStore;
		logic [15:0] ins;
		kind = int'($urandom % 16);
		if (kind < 7) begin
			ins = aluInstr($urandom % 8, $urandom % 6, $urandom % 8, 1'($urandom % 2),
				$urandom % 16);
		end else if (kind < 11) begin
			isStore = 1'($urandom % 2);
			// r6 and r7 hold the data-area bases and are never written
			ins = {2'b01, isStore, 1'($urandom % 2), 1'b0,
				3'(isStore ? $urandom % 8 : $urandom % 6), 3'(6 + $urandom % 2),
				5'($urandom % 32)};
		end else if (kind < 14 && at + 4 < PROG_LEN) begin
			cond = int'($urandom % 4);
			ins = {2'b10, 2'(cond), 1'b0, 3'(cond == 3 ? $urandom % 6 : $urandom % 8),
				8'(1 + $urandom % 4)};
		end else begin
			ins = 16'h0000;
		end
		return ins;
	endfunction

	task automatic buildImage();
		// r7 = 128, r6 = 192
		image[0] = aluInstr(OP_MOV, 7, 0, 1'b1, 1);
		for (int i = 1; i <= 7; i++)
			image[i] = aluInstr(OP_SHL1, 7, 0, 1'b0, 0);
		image[8] = aluInstr(OP_MOV, 6, 0, 1'b1, 3);
		for (int i = 9; i <= 14; i++)
			image[i] = aluInstr(OP_SHL1, 6, 0, 1'b0, 0);
		for (int i = 15; i < PROG_LEN - 1; i++)
			image[i] = randomInstr(i);
		for (int i = PROG_LEN - 1; i < 128; i++)
			image[i] = HALT;
		for (int i = 128; i < 256; i++)
			image[i] = 16'($urandom);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// memory model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin : memoryModel
		logic       pending;
		int         delay;
		logic [7:0] readAddr;
		pending      = 1'b0;
		delay        = 0;
		readAddr     = 8'h00;
		memReqReady  = 1'b0;
		memRespValid = 1'b0;
		memRdata     = '0;
		forever begin
			@(posedge CLK);
			if (rst) begin
				for (int i = 0; i < 256; i++)
					mem[i] = image[i];
				pending = 1'b0;
			end else if (memReqValid && memReqReady) begin
				if (memWe) begin
					if (memByteEn == 2'b01)
						mem[memAddr][7:0] = memWdata[7:0];
					else
						mem[memAddr] = memWdata;
				end else begin
					pending  = 1'b1;
					readAddr = memAddr;
					delay    = int'($urandom % 3);
				end
			end
			@(negedge CLK);
			memRespValid = 1'b0;
			// garbage on the data lines unless a response is due
			memRdata     = 16'($urandom);
			if (pending) begin
				if (delay == 0) begin
					memRespValid = 1'b1;
					memRdata     = mem[readAddr];
					pending      = 1'b0;
				end else begin
					delay--;
				end
			end
			memReqReady = !rst && ($urandom % 4 != 0);
		end
	end

	initial begin : stimulus
		int prevErrors;
		int totalRetired;
		prevErrors   = 0;
		totalRetired = 0;
		rst          = 1'b1;
		void'($urandom(SEED));
		for (int t = 0; t < NUM_TESTS; t++) begin
			@(negedge CLK);
			rst = 1'b1;
			buildImage();
			repeat (RESET_CYCLES) @(negedge CLK);
			rst = 1'b0;
			while (!halted)
				@(negedge CLK);
			// nothing may follow the halt
			repeat (QUIET_CYCLES) @(negedge CLK);
			totalRetired += retired;
			$display("test %0d: %0d instructions retired, %0d errors", t, retired,
				errors - prevErrors);
			prevErrors = errors;
		end
		$display("%0d tests, %0d instructions retired, %0d errors", NUM_TESTS, totalRetired,
			errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("timeout: the core did not reach halt within %0d ns", TIMEOUT_NS);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
src/corePkg.sv
src/ctrlIf.sv
src/phaseSequencer.sv
src/groupDecode.sv
src/controlSelect.sv
src/registerFile.sv
src/executeUnit.sv
src/resultCommit.sv
src/coreTop.sv
sim/coreChecker.sv
sim/coreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module coreTb -f files.f -o coreSim

output=$(./obj_dir/coreSim)
echo "$output"

if grep -qx "TEST PASSED" <<< "$output"; then
	exit 0
else
	exit 1
fi
